//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // line geometry
    localparam int line_bytes  = 32;
    localparam int offset_bits = $clog2(line_bytes);

    // processor side data width
    localparam int word_bits = 32;

    // one full cache line, byte 0 in the low bits
    typedef logic [line_bytes*8-1:0] cache_line_t;

    // controller states
    typedef enum logic [1:0] {
        idle,
        compare,
        write_back,
        fill
    } dcache_state_e;

endpackage

`default_nettype wire

//--- dcache/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
    parameter int width    = 1,
    parameter int idx_bits = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                write,
    input  logic [idx_bits-1:0] index,
    input  logic [width-1:0]    datain,
    output logic [width-1:0]    dataout
);

    localparam int depth = 2 ** idx_bits;

    logic [width-1:0] entries [depth];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

    // read is combinational
    assign dataout = entries[index];

endmodule

`default_nettype wire

//--- dcache/dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath #(
    parameter int set_bits = 3
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [31:0]                      mem_address,
    input  logic [dcache_pkg::word_bits-1:0] merged_word,
    input  dcache_pkg::cache_line_t          pmem_rdata,
    input  logic                             load_line_data,
    input  logic                             load_valid,
    input  logic                             load_dirty,
    input  logic                             load_lru,
    input  logic                             load_wb_line,
    input  logic                             line_from_mem,
    input  logic                             dirty_in,
    input  logic                             use_lru_way,
    input  logic                             addr_from_wb,
    output logic [dcache_pkg::word_bits-1:0] stored_word,
    output logic                             hit,
    output logic                             victim_valid,
    output logic                             victim_dirty,
    output logic [31:0]                      pmem_address,
    output dcache_pkg::cache_line_t          pmem_wdata
);
    import dcache_pkg::*;

    localparam int tag_bits      = 32 - set_bits - offset_bits;
    localparam int word_sel_bits = $clog2(line_bytes / (word_bits / 8));

    logic [tag_bits-1:0]      tag;
    logic [set_bits-1:0]      index;
    logic [word_sel_bits-1:0] word_offset;

    logic [7:0]          way_bytes [2][line_bytes];
    logic [tag_bits-1:0] tag_out [2];
    logic                valid_out [2];
    logic                dirty_out [2];
    logic                hit_way [2];
    logic                load_data_way [2];
    logic                load_valid_way [2];
    logic                load_dirty_way [2];
    cache_line_t         way_line [2];

    logic        lru_out;
    logic        active_way;
    cache_line_t active_line;
    cache_line_t merged_line;
    cache_line_t line_in;
    cache_line_t wb_line;
    logic [31:0] wb_addr;

    // address split
    assign tag         = mem_address[31:offset_bits+set_bits];
    assign index       = mem_address[offset_bits +: set_bits];
    assign word_offset = mem_address[offset_bits-1 -: word_sel_bits];

    genvar w;
    genvar b;
    generate
        for (w = 0; w < 2; w++) begin : g_way
            localparam logic way_id = 1'(w);

            for (b = 0; b < line_bytes; b++) begin : g_byte
                dcache_array #(.width(8), .idx_bits(set_bits)) u_data (
                    .clk,
                    .arst_n,
                    .write   (load_data_way[w]),
                    .index,
                    .datain  (line_in[b*8 +: 8]),
                    .dataout (way_bytes[w][b])
                );
            end

            dcache_array #(.width(tag_bits), .idx_bits(set_bits)) u_tag (
                .clk,
                .arst_n,
                .write   (load_data_way[w]),
                .index,
                .datain  (tag),
                .dataout (tag_out[w])
            );

            dcache_array #(.width(1), .idx_bits(set_bits)) u_valid (
                .clk,
                .arst_n,
                .write   (load_valid_way[w]),
                .index,
                .datain  (1'b1),
                .dataout (valid_out[w])
            );

            dcache_array #(.width(1), .idx_bits(set_bits)) u_dirty (
                .clk,
                .arst_n,
                .write   (load_dirty_way[w]),
                .index,
                .datain  (dirty_in),
                .dataout (dirty_out[w])
            );

            assign hit_way[w]        = valid_out[w] && (tag_out[w] == tag);
            assign load_data_way[w]  = load_line_data && (active_way == way_id);
            assign load_valid_way[w] = load_valid && (active_way == way_id);
            assign load_dirty_way[w] = load_dirty && (active_way == way_id);
        end
    endgenerate

    // lru points at the way to replace next
    dcache_array #(.width(1), .idx_bits(set_bits)) u_lru (
        .clk,
        .arst_n,
        .write   (load_lru),
        .index,
        .datain  (~active_way),
        .dataout (lru_out)
    );

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < line_bytes; j++) begin
                way_line[i][j*8 +: 8] = way_bytes[i][j];
            end
        end
    end

    assign hit          = hit_way[0] || hit_way[1];
    assign active_way   = use_lru_way ? lru_out : hit_way[1];
    assign active_line  = way_line[active_way];
    assign victim_valid = valid_out[lru_out];
    assign victim_dirty = dirty_out[lru_out];

    assign stored_word = active_line[word_offset*word_bits +: word_bits];

    // store word dropped into its slot
    always_comb begin
        merged_line = active_line;
        merged_line[word_offset*word_bits +: word_bits] = merged_word;
    end

    assign line_in = line_from_mem ? pmem_rdata : merged_line;

    // write-back line register
    always_ff @(posedge clk) begin
        if (load_wb_line) begin
            wb_line <= active_line;
            wb_addr <= {tag_out[active_way], index, {offset_bits{1'b0}}};
        end
    end

    assign pmem_wdata   = wb_line;
    assign pmem_address = addr_from_wb ? wb_addr
                                       : {mem_address[31:offset_bits], {offset_bits{1'b0}}};

endmodule

`default_nettype wire

//--- dcache/dcache_control.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_control (
    input  logic clk,
    input  logic arst_n,
    input  logic mem_read,
    input  logic mem_write,
    input  logic hit,
    input  logic victim_valid,
    input  logic victim_dirty,
    input  logic pmem_resp,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic load_wb_line,
    output logic line_from_mem,
    output logic dirty_in,
    output logic use_lru_way,
    output logic addr_from_wb
);
    import dcache_pkg::*;

    dcache_state_e state;
    dcache_state_e next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        mem_resp       = 1'b0;
        pmem_read      = 1'b0;
        pmem_write     = 1'b0;
        load_line_data = 1'b0;
        load_valid     = 1'b0;
        load_dirty     = 1'b0;
        load_lru       = 1'b0;
        load_wb_line   = 1'b0;
        line_from_mem  = 1'b0;
        dirty_in       = 1'b0;
        use_lru_way    = 1'b0;
        addr_from_wb   = 1'b0;

        case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    next_state = compare;
                end
            end

            compare: begin
                if (hit) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    // write hit updates line and marks it dirty
                    if (mem_write) begin
                        load_line_data = 1'b1;
                        load_dirty     = 1'b1;
                        dirty_in       = 1'b1;
                    end
                    next_state = idle;
                end else begin
                    // capture victim before anything is replaced
                    use_lru_way  = 1'b1;
                    load_wb_line = 1'b1;
                    if (victim_valid && victim_dirty) begin
                        next_state = write_back;
                    end else begin
                        next_state = fill;
                    end
                end
            end

            write_back: begin
                pmem_write   = 1'b1;
                addr_from_wb = 1'b1;
                if (pmem_resp) begin
                    next_state = fill;
                end
            end

            fill: begin
                pmem_read   = 1'b1;
                use_lru_way = 1'b1;
                if (pmem_resp) begin
                    load_line_data = 1'b1;
                    line_from_mem  = 1'b1;
                    load_valid     = 1'b1;
                    load_dirty     = 1'b1;
                    next_state     = compare;
                end
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/byte_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_align (
    input  logic [1:0]                         alignment,
    input  logic [dcache_pkg::word_bits-1:0]   stored_word,
    input  logic [dcache_pkg::word_bits-1:0]   mem_wdata,
    input  logic [dcache_pkg::word_bits/8-1:0] mem_byte_enable,
    output logic [dcache_pkg::word_bits-1:0]   mem_rdata,
    output logic [dcache_pkg::word_bits-1:0]   merged_word
);
    import dcache_pkg::*;

    localparam int lanes = word_bits / 8;

    logic [word_bits-1:0] shifted_data;
    logic [lanes-1:0]     shifted_be;

    // misaligned load, upper bytes zero
    assign mem_rdata = stored_word >> {alignment, 3'b000};

    // lanes pushed past the top byte fall off
    assign shifted_data = mem_wdata << {alignment, 3'b000};
    assign shifted_be   = mem_byte_enable << alignment;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            if (shifted_be[i]) begin
                merged_word[i*8 +: 8] = shifted_data[i*8 +: 8];
            end else begin
                merged_word[i*8 +: 8] = stored_word[i*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int set_bits = 3
) (
    input  logic                    clk,
    input  logic                    arst_n,
    // processor port
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  logic [31:0]             mem_address,
    input  logic [31:0]             mem_wdata,
    input  logic [3:0]              mem_byte_enable,
    output logic [31:0]             mem_rdata,
    output logic                    mem_resp,
    // memory port
    output logic                    pmem_read,
    output logic                    pmem_write,
    output logic [31:0]             pmem_address,
    output dcache_pkg::cache_line_t pmem_wdata,
    input  dcache_pkg::cache_line_t pmem_rdata,
    input  logic                    pmem_resp
);

    logic [31:0] stored_word;
    logic [31:0] merged_word;
    logic        hit;
    logic        victim_valid;
    logic        victim_dirty;
    logic        load_line_data;
    logic        load_valid;
    logic        load_dirty;
    logic        load_lru;
    logic        load_wb_line;
    logic        line_from_mem;
    logic        dirty_in;
    logic        use_lru_way;
    logic        addr_from_wb;

    dcache_datapath #(.set_bits(set_bits)) u_datapath (
        .clk,
        .arst_n,
        .mem_address,
        .merged_word,
        .pmem_rdata,
        .load_line_data,
        .load_valid,
        .load_dirty,
        .load_lru,
        .load_wb_line,
        .line_from_mem,
        .dirty_in,
        .use_lru_way,
        .addr_from_wb,
        .stored_word,
        .hit,
        .victim_valid,
        .victim_dirty,
        .pmem_address,
        .pmem_wdata
    );

    dcache_control u_control (
        .clk,
        .arst_n,
        .mem_read,
        .mem_write,
        .hit,
        .victim_valid,
        .victim_dirty,
        .pmem_resp,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .load_line_data,
        .load_valid,
        .load_dirty,
        .load_lru,
        .load_wb_line,
        .line_from_mem,
        .dirty_in,
        .use_lru_way,
        .addr_from_wb
    );

    byte_lane_align u_align (
        .alignment       (mem_address[1:0]),
        .stored_word,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .merged_word
    );

endmodule

`default_nettype wire

//--- bench/dcache_props.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_props (
    input logic                      clk,
    input logic                      arst_n,
    input dcache_pkg::dcache_state_e state,
    input logic                      mem_read,
    input logic                      mem_write,
    input logic                      mem_resp,
    input logic                      pmem_read,
    input logic                      pmem_write
);
    import dcache_pkg::*;

    a_pmem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    a_resp_single: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |=> !mem_resp)
        else $error("mem_resp held for two cycles");

    // nothing leaves the cache while it waits for a request
    a_quiet_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read || mem_write) |->
            (state == idle) && !(mem_resp || pmem_read || pmem_write))
        else $error("cache busy or responding with no request present");

endmodule

bind dcache_control dcache_props u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .state      (state),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
);

`default_nettype wire

//--- bench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int set_bits       = 3;
    localparam int tag_bits       = 32 - set_bits - offset_bits;
    localparam int num_accesses   = 600;
    localparam int timeout_cycles = 16 + num_accesses * 20;

    logic        clk;
    logic        arst_n;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_address;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_byte_enable;
    logic [31:0] mem_rdata;
    logic        mem_resp;
    logic        pmem_read;
    logic        pmem_write;
    logic [31:0] pmem_address;
    cache_line_t pmem_wdata;
    cache_line_t pmem_rdata = '0;
    logic        pmem_resp  = 1'b0;

    // reference byte memory and the responder's line memory
    logic [7:0]  model_mem [logic [31:0]];
    cache_line_t mem_lines [logic [31:0]];
    bit          line_dirty [logic [26:0]];
    logic [26:0] recent_line [8][2];
    int          recent_cnt [8] = '{default: 0};

    logic [tag_bits-1:0] tag_pool [3] = '{24'h00a3c1, 24'h5e0017, 24'hf19b24};
    logic [31:0] stim_state  = 32'd96180;
    logic [31:0] resp_state  = 32'd96180 ^ 32'h2545f491;
    int          resp_wait   = 0;
    int          cycle_count = 0;
    int          errors      = 0;
    int          checks      = 0;

    dcache_top #(.set_bits(set_bits)) u_dut (
        .clk,
        .arst_n,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata,
        .pmem_rdata,
        .pmem_resp
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // power-up content, every address bit folded in
    function automatic logic [7:0] init_byte(input logic [31:0] addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] addr);
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        return init_byte(addr);
    endfunction

    function automatic cache_line_t model_line(input logic [31:0] base);
        cache_line_t line;
        for (int i = 0; i < line_bytes; i++) begin
            line[i*8 +: 8] = model_byte(base + 32'(i));
        end
        return line;
    endfunction

    function automatic cache_line_t backing_line(input logic [31:0] base);
        cache_line_t line;
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int i = 0; i < line_bytes; i++) begin
            line[i*8 +: 8] = init_byte(base + 32'(i));
        end
        return line;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] got);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: accesses did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // memory side, 1 to 6 cycles per transfer
    always @(posedge clk) begin
        if (pmem_resp) begin
            pmem_resp <= 1'b0;
        end else if (arst_n && (pmem_read || pmem_write)) begin
            if (resp_wait == 0) begin
                resp_state = xorshift32(resp_state);
                resp_wait  = 1 + int'(resp_state % 6);
            end
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                if (pmem_write) begin
                    mem_lines[pmem_address] = pmem_wdata;
                end else begin
                    pmem_rdata <= backing_line(pmem_address);
                end
                pmem_resp <= 1'b1;
            end
        end
    end

    task automatic run_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] base;
        logic [31:0] waddr;
        logic [26:0] line;
        logic [31:0] wb_base;
        logic [31:0] exp_word;
        logic [3:0]  lane_be;
        logic [31:0] lane_data;
        int          set_idx;
        int          n_rd;
        int          n_wr;
        bit          recent_hit;
        bit          expect_wb;
        bit          done;

        base       = {addr[31:offset_bits], {offset_bits{1'b0}}};
        waddr      = {addr[31:2], 2'b00};
        line       = addr[31:offset_bits];
        set_idx    = int'(addr[offset_bits +: set_bits]);
        wb_base    = '0;
        n_rd       = 0;
        n_wr       = 0;
        recent_hit = 1'b0;
        expect_wb  = 1'b0;
        done       = 1'b0;
        for (int k = 0; k < recent_cnt[set_idx]; k++) begin
            if (recent_line[set_idx][k] == line) begin
                recent_hit = 1'b1;
            end
        end
        // third line in a full set evicts the older one
        if (!recent_hit && recent_cnt[set_idx] == 2) begin
            wb_base   = {recent_line[set_idx][1], {offset_bits{1'b0}}};
            expect_wb = line_dirty.exists(recent_line[set_idx][1]);
        end

        @(posedge clk);
        mem_read        <= !wr;
        mem_write       <= wr;
        mem_address     <= addr;
        mem_wdata       <= wdata;
        mem_byte_enable <= be;

        while (!done) begin
            @(negedge clk);
            if (pmem_resp && pmem_write) begin
                n_wr++;
                checks += 2;
                if (pmem_address != wb_base) begin
                    report_mismatch("pmem_address (write-back)", wb_base, pmem_address);
                end
                if (pmem_wdata != model_line(wb_base)) begin
                    report_mismatch("pmem_wdata", model_line(wb_base), pmem_wdata);
                end
            end
            if (pmem_resp && pmem_read) begin
                n_rd++;
                checks++;
                if (pmem_address != base) begin
                    report_mismatch("pmem_address (fill)", base, pmem_address);
                end
            end
            if (mem_resp) begin
                done = 1'b1;
                if (!wr) begin
                    exp_word = {model_byte(waddr + 3), model_byte(waddr + 2),
                                model_byte(waddr + 1), model_byte(waddr)};
                    exp_word = exp_word >> {addr[1:0], 3'b000};
                    checks++;
                    if (mem_rdata != exp_word) begin
                        report_mismatch("mem_rdata", exp_word, mem_rdata);
                    end
                end
            end
        end

        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;

        checks += 2;
        if (n_rd != (recent_hit ? 0 : 1)) begin
            report_mismatch("pmem_read count", recent_hit ? 0 : 1, n_rd);
        end
        if (n_wr != (expect_wb ? 1 : 0)) begin
            report_mismatch("pmem_write count", expect_wb ? 1 : 0, n_wr);
        end

        if (recent_hit) begin
            if (recent_line[set_idx][0] != line) begin
                recent_line[set_idx][1] = recent_line[set_idx][0];
                recent_line[set_idx][0] = line;
            end
        end else begin
            if (recent_cnt[set_idx] == 2) begin
                line_dirty.delete(recent_line[set_idx][1]);
            end else begin
                recent_cnt[set_idx]++;
            end
            recent_line[set_idx][1] = recent_line[set_idx][0];
            recent_line[set_idx][0] = line;
        end

        if (wr) begin
            line_dirty[line] = 1'b1;
            lane_be   = be << addr[1:0];
            lane_data = wdata << {addr[1:0], 3'b000};
            for (int i = 0; i < 4; i++) begin
                if (lane_be[i]) begin
                    model_mem[waddr + 32'(i)] = lane_data[i*8 +: 8];
                end
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic [2:0]  set_sel;

        arst_n          <= 1'b0;
        mem_read        <= 1'b0;
        mem_write       <= 1'b0;
        mem_address     <= '0;
        mem_wdata       <= '0;
        mem_byte_enable <= '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int n = 0; n < num_accesses; n++) begin
            stim_state = xorshift32(stim_state);
            r          = stim_state;
            stim_state = xorshift32(stim_state);
            wdata      = stim_state;
            // three tags over sets 2 and 5
            set_sel = r[2] ? 3'd5 : 3'd2;
            addr    = {tag_pool[r[31:16] % 3], set_sel, r[7:5], r[9:8]};
            run_access(r[3], addr, wdata, r[13:10]);
        end

        @(posedge clk);
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_datapath.sv
dcache/dcache_control.sv
verilog/byte_lane_align.sv
verilog/dcache_top.sv
bench/dcache_props.sv
bench/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module dcache_tb \
    -o dcache_sim > build.log 2>&1 \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || echo "build or simulation exited with an error"

grep -qx "TEST PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log and build.log"; exit 1; }
